/* csrPkg.sv */
package csrPkg;

    // Machine word and CSR field widths
    typedef logic [63:0] dataT;
    typedef logic [11:0] csrAddrT;
    typedef logic [3:0]  causeT;
    typedef logic [15:0] exceptVecT;
    typedef logic [1:0]  privModeT;

    // AXI4-Lite side
    typedef logic [7:0] hostOffT;
    typedef logic [7:0] strbT;
    typedef logic [1:0] axiRespT;

    localparam privModeT PRIV_USER    = 2'd0;
    localparam privModeT PRIV_MACHINE = 2'd3;

    localparam csrAddrT CSR_MSTATUS  = 12'h300;
    localparam csrAddrT CSR_MTVEC    = 12'h305;
    localparam csrAddrT CSR_MSCRATCH = 12'h340;
    localparam csrAddrT CSR_MEPC     = 12'h341;
    localparam csrAddrT CSR_MCAUSE   = 12'h342;
    localparam csrAddrT CSR_MCYCLE   = 12'hB00;

    // mstatus bit positions
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MSTATUS_MPP  = 11;

    localparam hostOffT HOST_CTRL   = 8'h00;
    localparam hostOffT HOST_CMP    = 8'h08;
    localparam hostOffT HOST_CYCLE  = 8'h10;
    localparam hostOffT HOST_STATUS = 8'h18;

    localparam axiRespT RESP_OKAY   = 2'b00;
    localparam axiRespT RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic    valid;
        logic    write;
        csrAddrT addr;
        dataT    wdata;
    } csrReqT;

    typedef enum logic {WR_IDLE, WR_RESP} hostWrStateT;
    typedef enum logic {RD_IDLE, RD_RESP} hostRdStateT;

endpackage

/* mstatusReg.sv */
module mstatusReg (
    input  logic             clk,
    input  logic             arstN,
    input  logic             trapTaken,
    input  logic             trapReturn,
    input  logic             wrEn,
    input  csrPkg::dataT     wdata,
    output csrPkg::dataT     mstatus,
    output csrPkg::privModeT privMode
);

    logic             mie;
    logic             mpie;
    csrPkg::privModeT mpp;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mie      <= 1'b0;
            mpie     <= 1'b0;
            mpp      <= csrPkg::PRIV_USER;
            privMode <= csrPkg::PRIV_MACHINE;
        end else if (trapTaken) begin
            // Stack the interrupt enable and mode
            mpie     <= mie;
            mie      <= 1'b0;
            mpp      <= privMode;
            privMode <= csrPkg::PRIV_MACHINE;
        end else if (trapReturn) begin
            mie      <= mpie;
            mpie     <= 1'b1;
            privMode <= mpp;
            mpp      <= csrPkg::PRIV_USER;
        end else if (wrEn) begin
            mie  <= wdata[csrPkg::MSTATUS_MIE];
            mpie <= wdata[csrPkg::MSTATUS_MPIE];
            mpp  <= wdata[csrPkg::MSTATUS_MPP +: 2];
        end
    end

    always_comb begin
        mstatus                            = '0;
        mstatus[csrPkg::MSTATUS_MIE]       = mie;
        mstatus[csrPkg::MSTATUS_MPIE]      = mpie;
        mstatus[csrPkg::MSTATUS_MPP +: 2]  = mpp;
    end

endmodule

/* trapUnit.sv */
module trapUnit #(
    parameter csrPkg::dataT MTVEC_RESET = 64'h0
) (
    input  logic              clk,
    input  logic              arstN,
    input  csrPkg::exceptVecT exceptVec,
    input  csrPkg::dataT      pc,
    input  csrPkg::dataT      wdata,
    input  logic              trapReturn,
    input  logic              mtvecWrEn,
    input  logic              mepcWrEn,
    input  logic              mcauseWrEn,
    output logic              trapTaken,
    output logic              redirect,
    output csrPkg::dataT      redirectPc,
    output csrPkg::dataT      mtvec,
    output csrPkg::dataT      mepc,
    output csrPkg::dataT      mcause
);

    csrPkg::causeT cause;

    // Lowest exception code wins
    function automatic csrPkg::causeT lowestSet(input csrPkg::exceptVecT vec);
        csrPkg::causeT idx;
        idx = '0;
        for (int i = $bits(csrPkg::exceptVecT) - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = csrPkg::causeT'(i);
            end
        end
        return idx;
    endfunction

    assign cause     = lowestSet(exceptVec);
    assign trapTaken = |exceptVec;
    assign redirect  = trapTaken | trapReturn;

    always_comb begin
        if (trapTaken) begin
            redirectPc = {mtvec[63:2], 2'b00};
        end else begin
            redirectPc = mepc;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mtvec <= MTVEC_RESET;
        end else if (mtvecWrEn && !trapTaken) begin
            mtvec <= wdata;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mepc   <= '0;
            mcause <= '0;
        end else if (trapTaken) begin
            mepc   <= pc;
            mcause <= csrPkg::dataT'(cause);
        end else begin
            if (mepcWrEn) begin
                mepc <= wdata;
            end
            if (mcauseWrEn) begin
                mcause <= wdata;
            end
        end
    end

endmodule

/* cycleCounter.sv */
module cycleCounter (
    input  logic         clk,
    input  logic         arstN,
    input  logic         halt,
    input  logic         arm,
    input  csrPkg::dataT cmpValue,
    output csrPkg::dataT mcycle,
    output logic         stalled
);

    logic cmpHit;

    // Armed compare stops the count on the matching value
    assign cmpHit  = arm && (mcycle == cmpValue);
    assign stalled = halt | cmpHit;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mcycle <= '0;
        end else if (!stalled) begin
            mcycle <= mcycle + csrPkg::dataT'(1);
        end
    end

endmodule

/* hostBridge.sv */
module hostBridge #(
    parameter int HOST_ADDR_WIDTH = 8
) (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic [HOST_ADDR_WIDTH-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  csrPkg::dataT               wdata,
    input  csrPkg::strbT               wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output csrPkg::axiRespT            bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [HOST_ADDR_WIDTH-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output csrPkg::dataT               rdata,
    output csrPkg::axiRespT            rresp,
    output logic                       rvalid,
    input  logic                       rready,
    input  csrPkg::dataT               mcycle,
    input  logic                       stalled,
    input  csrPkg::privModeT           privMode,
    output logic                       halt,
    output logic                       arm,
    output csrPkg::dataT               cmpValue
);

    csrPkg::hostWrStateT wrState;
    csrPkg::hostRdStateT rdState;
    logic                wrFire;
    logic                rdFire;

    function automatic logic isOff(input logic [HOST_ADDR_WIDTH-1:0] addr,
                                   input csrPkg::hostOffT off);
        return addr == HOST_ADDR_WIDTH'(off);
    endfunction

    // Address and data taken together, one write outstanding
    assign wrFire  = (wrState == csrPkg::WR_IDLE) && awvalid && wvalid;
    assign awready = wrFire;
    assign wready  = wrFire;
    assign bvalid  = (wrState == csrPkg::WR_RESP);

    assign arready = (rdState == csrPkg::RD_IDLE);
    assign rdFire  = arready && arvalid;
    assign rvalid  = (rdState == csrPkg::RD_RESP);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrState  <= csrPkg::WR_IDLE;
            bresp    <= csrPkg::RESP_OKAY;
            halt     <= 1'b0;
            arm      <= 1'b0;
            cmpValue <= '0;
        end else if (wrFire) begin
            wrState <= csrPkg::WR_RESP;
            bresp   <= csrPkg::RESP_OKAY;
            if (isOff(awaddr, csrPkg::HOST_CTRL)) begin
                if (wstrb[0]) begin
                    halt <= wdata[0];
                    arm  <= wdata[1];
                end
            end else if (isOff(awaddr, csrPkg::HOST_CMP)) begin
                for (int i = 0; i < $bits(csrPkg::strbT); i++) begin
                    if (wstrb[i]) begin
                        cmpValue[8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end else begin
                // Read-only or unmapped
                bresp <= csrPkg::RESP_SLVERR;
            end
        end else if (bvalid && bready) begin
            wrState <= csrPkg::WR_IDLE;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdState <= csrPkg::RD_IDLE;
            rdata   <= '0;
            rresp   <= csrPkg::RESP_OKAY;
        end else if (rdFire) begin
            rdState <= csrPkg::RD_RESP;
            rresp   <= csrPkg::RESP_OKAY;
            if (isOff(araddr, csrPkg::HOST_CTRL)) begin
                rdata <= {62'b0, arm, halt};
            end else if (isOff(araddr, csrPkg::HOST_CMP)) begin
                rdata <= cmpValue;
            end else if (isOff(araddr, csrPkg::HOST_CYCLE)) begin
                rdata <= mcycle;
            end else if (isOff(araddr, csrPkg::HOST_STATUS)) begin
                rdata <= {61'b0, privMode, stalled};
            end else begin
                rdata <= '0;
                rresp <= csrPkg::RESP_SLVERR;
            end
        end else if (rvalid && rready) begin
            rdState <= csrPkg::RD_IDLE;
        end
    end

endmodule

/* machineCsrUnit.sv */
module machineCsrUnit #(
    parameter csrPkg::dataT MTVEC_RESET     = 64'h0,
    parameter int           HOST_ADDR_WIDTH = 8
) (
    input  logic                       clk,
    input  logic                       arstN,
    input  csrPkg::csrReqT             csrReq,
    input  csrPkg::exceptVecT          exceptVec,
    input  csrPkg::dataT               pc,
    input  logic                       trapReturn,
    output csrPkg::dataT               csrRdata,
    output logic                       redirect,
    output csrPkg::dataT               redirectPc,
    output csrPkg::privModeT           privMode,
    output logic                       stall,
    input  logic [HOST_ADDR_WIDTH-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  csrPkg::dataT               wdata,
    input  csrPkg::strbT               wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output csrPkg::axiRespT            bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [HOST_ADDR_WIDTH-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output csrPkg::dataT               rdata,
    output csrPkg::axiRespT            rresp,
    output logic                       rvalid,
    input  logic                       rready
);

    csrPkg::dataT mscratch;
    csrPkg::dataT mstatus;
    csrPkg::dataT mtvec;
    csrPkg::dataT mepc;
    csrPkg::dataT mcause;
    csrPkg::dataT mcycle;
    csrPkg::dataT cmpValue;
    logic         trapTaken;
    logic         csrWrite;
    logic         halt;
    logic         arm;

    // A trap in the same cycle drops the CSR write
    assign csrWrite = csrReq.valid && csrReq.write && !trapTaken;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mscratch <= '0;
        end else if (csrWrite && csrReq.addr == csrPkg::CSR_MSCRATCH) begin
            mscratch <= csrReq.wdata;
        end
    end

    always_comb begin
        case (csrReq.addr)
            csrPkg::CSR_MSTATUS:  csrRdata = mstatus;
            csrPkg::CSR_MTVEC:    csrRdata = mtvec;
            csrPkg::CSR_MSCRATCH: csrRdata = mscratch;
            csrPkg::CSR_MEPC:     csrRdata = mepc;
            csrPkg::CSR_MCAUSE:   csrRdata = mcause;
            csrPkg::CSR_MCYCLE:   csrRdata = mcycle;
            default:              csrRdata = '0;
        endcase
    end

    mstatusReg u_mstatusReg (
        .clk       (clk),
        .arstN     (arstN),
        .trapTaken (trapTaken),
        .trapReturn(trapReturn),
        .wrEn      (csrWrite && csrReq.addr == csrPkg::CSR_MSTATUS),
        .wdata     (csrReq.wdata),
        .mstatus   (mstatus),
        .privMode  (privMode)
    );

    trapUnit #(
        .MTVEC_RESET(MTVEC_RESET)
    ) u_trapUnit (
        .clk       (clk),
        .arstN     (arstN),
        .exceptVec (exceptVec),
        .pc        (pc),
        .wdata     (csrReq.wdata),
        .trapReturn(trapReturn),
        .mtvecWrEn (csrWrite && csrReq.addr == csrPkg::CSR_MTVEC),
        .mepcWrEn  (csrWrite && csrReq.addr == csrPkg::CSR_MEPC),
        .mcauseWrEn(csrWrite && csrReq.addr == csrPkg::CSR_MCAUSE),
        .trapTaken (trapTaken),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .mtvec     (mtvec),
        .mepc      (mepc),
        .mcause    (mcause)
    );

    cycleCounter u_cycleCounter (
        .clk     (clk),
        .arstN   (arstN),
        .halt    (halt),
        .arm     (arm),
        .cmpValue(cmpValue),
        .mcycle  (mcycle),
        .stalled (stall)
    );

    hostBridge #(
        .HOST_ADDR_WIDTH(HOST_ADDR_WIDTH)
    ) u_hostBridge (
        .clk     (clk),
        .arstN   (arstN),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .mcycle  (mcycle),
        .stalled (stall),
        .privMode(privMode),
        .halt    (halt),
        .arm     (arm),
        .cmpValue(cmpValue)
    );

endmodule

/* machineCsr_props.sv */
module machineCsrProps (
    input logic         clk,
    input logic         arstN,
    input logic         bvalid,
    input logic         bready,
    input logic         rvalid,
    input logic         rready,
    input csrPkg::dataT rdata,
    input csrPkg::dataT mcycle,
    input logic         stalled
);

    timeunit 1ns;
    timeprecision 100ps;

    bvalidHold: assert property (@(posedge clk) disable iff (!arstN)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rvalidHold: assert property (@(posedge clk) disable iff (!arstN)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // Read data frozen while the host waits
    rdataStable: assert property (@(posedge clk) disable iff (!arstN)
        rvalid && !rready |=> $stable(rdata))
        else $error("rdata changed while rvalid waited");

    mcycleFrozen: assert property (@(posedge clk) disable iff (!arstN)
        stalled |=> $stable(mcycle))
        else $error("mcycle moved while stalled");

endmodule

// The bridge sees the counter outputs on its own ports
bind hostBridge machineCsrProps u_machineCsrProps (
    .clk    (clk),
    .arstN  (arstN),
    .bvalid (bvalid),
    .bready (bready),
    .rvalid (rvalid),
    .rready (rready),
    .rdata  (rdata),
    .mcycle (mcycle),
    .stalled(stalled)
);

/* machineCsrTb.sv */
module machineCsrTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam csrPkg::dataT    MTVEC_RESET     = 64'h1000;
    localparam int              HOST_ADDR_WIDTH = 8;
    localparam int              RESET_CYCLES    = 8;
    localparam int              DRIVE_DELAY     = 2;
    localparam int              RANDOM_OPS      = 300;
    localparam int              BP_CYCLES       = 4;
    localparam csrPkg::csrAddrT UNKNOWN_CSR     = 12'h7C0;
    // Directed parts take a few hundred cycles on top of the random ops
    localparam int              TIMEOUT_CYCLES  = 4000;

    typedef struct packed {
        csrPkg::dataT     mscratch;
        csrPkg::dataT     mtvec;
        csrPkg::dataT     mepc;
        csrPkg::dataT     mcause;
        logic             mie;
        logic             mpie;
        csrPkg::privModeT mpp;
        csrPkg::privModeT mode;
    } csrModelT;

    logic                       clk;
    logic                       arstN;
    csrPkg::csrReqT             csrReq;
    csrPkg::exceptVecT          exceptVec;
    csrPkg::dataT               pc;
    logic                       trapReturn;
    csrPkg::dataT               csrRdata;
    logic                       redirect;
    csrPkg::dataT               redirectPc;
    csrPkg::privModeT           privMode;
    logic                       stall;
    logic [HOST_ADDR_WIDTH-1:0] awaddr;
    logic                       awvalid;
    logic                       awready;
    csrPkg::dataT               wdata;
    csrPkg::strbT               wstrb;
    logic                       wvalid;
    logic                       wready;
    csrPkg::axiRespT            bresp;
    logic                       bvalid;
    logic                       bready;
    logic [HOST_ADDR_WIDTH-1:0] araddr;
    logic                       arvalid;
    logic                       arready;
    csrPkg::dataT               rdata;
    csrPkg::axiRespT            rresp;
    logic                       rvalid;
    logic                       rready;

    csrModelT     model;
    logic         expRedirect;
    csrPkg::dataT expPc;
    int           cycleCount = 0;

    machineCsrUnit #(
        .MTVEC_RESET    (MTVEC_RESET),
        .HOST_ADDR_WIDTH(HOST_ADDR_WIDTH)
    ) u_machineCsrUnit (
        .clk       (clk),
        .arstN     (arstN),
        .csrReq    (csrReq),
        .exceptVec (exceptVec),
        .pc        (pc),
        .trapReturn(trapReturn),
        .csrRdata  (csrRdata),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .privMode  (privMode),
        .stall     (stall),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    always #10 clk = ~clk;

    task automatic abortRun(input string line);
        $display("%s", line);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input csrPkg::dataT got, input csrPkg::dataT exp,
                              input string what);
        assert (got === exp) else begin
            abortRun($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            abortRun($sformatf("Error at %0t ns: %s does not hold", $time, what));
        end
    endtask

    function automatic csrModelT resetModel();
        csrModelT s;
        s       = '0;
        s.mtvec = MTVEC_RESET;
        s.mode  = csrPkg::PRIV_MACHINE;
        return s;
    endfunction

    // One clock edge of the CSR rules
    function automatic csrModelT nextModel(input csrModelT s, input csrPkg::csrReqT req,
                                           input csrPkg::exceptVecT ev,
                                           input csrPkg::dataT pcIn, input logic ret);
        csrModelT n;
        int       code;
        n = s;
        if (ev != '0) begin
            code = 0;
            while (!ev[code]) begin
                code++;
            end
            n.mepc   = pcIn;
            n.mcause = csrPkg::dataT'(code);
            n.mpie   = s.mie;
            n.mie    = 1'b0;
            n.mpp    = s.mode;
            n.mode   = csrPkg::PRIV_MACHINE;
        end else begin
            if (ret) begin
                n.mie  = s.mpie;
                n.mpie = 1'b1;
                n.mode = s.mpp;
                n.mpp  = csrPkg::PRIV_USER;
            end
            if (req.valid && req.write) begin
                case (req.addr)
                    // MIE 3, MPIE 7, MPP 12:11; the return update owns mstatus
                    csrPkg::CSR_MSTATUS: begin
                        if (!ret) begin
                            n.mie  = req.wdata[3];
                            n.mpie = req.wdata[7];
                            n.mpp  = req.wdata[12:11];
                        end
                    end
                    csrPkg::CSR_MTVEC:    n.mtvec    = req.wdata;
                    csrPkg::CSR_MSCRATCH: n.mscratch = req.wdata;
                    csrPkg::CSR_MEPC:     n.mepc     = req.wdata;
                    csrPkg::CSR_MCAUSE:   n.mcause   = req.wdata;
                    default: ;
                endcase
            end
        end
        return n;
    endfunction

    function automatic csrPkg::dataT expectedRead(input csrModelT s, input csrPkg::csrAddrT a);
        csrPkg::dataT d;
        d = '0;
        case (a)
            csrPkg::CSR_MSTATUS: begin
                d[3]     = s.mie;
                d[7]     = s.mpie;
                d[12:11] = s.mpp;
            end
            csrPkg::CSR_MTVEC:    d = s.mtvec;
            csrPkg::CSR_MSCRATCH: d = s.mscratch;
            csrPkg::CSR_MEPC:     d = s.mepc;
            csrPkg::CSR_MCAUSE:   d = s.mcause;
            default: ;
        endcase
        return d;
    endfunction

    function automatic csrPkg::csrAddrT pickAddr();
        case ($urandom % 8)
            0: return csrPkg::CSR_MSTATUS;
            1: return csrPkg::CSR_MTVEC;
            2: return csrPkg::CSR_MSCRATCH;
            3: return csrPkg::CSR_MEPC;
            4: return csrPkg::CSR_MCAUSE;
            5: return csrPkg::CSR_MCYCLE;
            6: return UNKNOWN_CSR;
            default: return csrPkg::csrAddrT'($urandom);
        endcase
    endfunction

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            model <= resetModel();
        end else begin
            model <= nextModel(model, csrReq, exceptVec, pc, trapReturn);
        end
    end

    // Outputs are settled half a cycle after the drive
    always @(negedge clk) begin
        if (arstN) begin
            expRedirect = (exceptVec != '0) || trapReturn;
            expPc       = (exceptVec != '0) ? {model.mtvec[63:2], 2'b00} : model.mepc;
            assert (redirect === expRedirect) else begin
                abortRun($sformatf("Error at %0t ns: redirect is %b, expected %b",
                                   $time, redirect, expRedirect));
            end
            if (expRedirect) begin
                assert (redirectPc === expPc) else begin
                    abortRun($sformatf("Error at %0t ns: redirectPc is %h, expected %h",
                                       $time, redirectPc, expPc));
                end
            end
            assert (privMode === model.mode) else begin
                abortRun($sformatf("Error at %0t ns: privMode is %0d, expected %0d",
                                   $time, privMode, model.mode));
            end
            // mcycle is checked over the host port
            if (csrReq.addr != csrPkg::CSR_MCYCLE) begin
                assert (csrRdata === expectedRead(model, csrReq.addr)) else begin
                    abortRun($sformatf("Error at %0t ns: csrRdata at %h is %h, expected %h",
                                       $time, csrReq.addr, csrRdata,
                                       expectedRead(model, csrReq.addr)));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            abortRun($sformatf("Timeout: the run did not finish within %0d clock cycles",
                               TIMEOUT_CYCLES));
        end
    end

    task automatic coreStep(input csrPkg::csrReqT req, input csrPkg::exceptVecT ev,
                            input csrPkg::dataT pcIn, input logic ret);
        csrReq     = req;
        exceptVec  = ev;
        pc         = pcIn;
        trapReturn = ret;
        @(posedge clk);
        #DRIVE_DELAY;
        csrReq     = '0;
        exceptVec  = '0;
        trapReturn = 1'b0;
    endtask

    task automatic coreRead(input csrPkg::csrAddrT addr, output csrPkg::dataT data);
        csrReq       = '0;
        csrReq.valid = 1'b1;
        csrReq.addr  = addr;
        @(negedge clk);
        data = csrRdata;
        @(posedge clk);
        #DRIVE_DELAY;
        csrReq = '0;
    endtask

    task automatic writeThenRead(input csrPkg::csrAddrT addr);
        csrPkg::csrReqT req;
        csrPkg::dataT   data;
        req       = '0;
        req.valid = 1'b1;
        req.write = 1'b1;
        req.addr  = addr;
        req.wdata = {$urandom, $urandom};
        coreStep(req, '0, '0, 1'b0);
        coreRead(addr, data);
        checkValue(data, req.wdata, "CSR readback");
    endtask

    task automatic hostWrite(input csrPkg::hostOffT addr, input csrPkg::dataT data,
                             output csrPkg::axiRespT resp);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 8'hFF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        do begin
            @(negedge clk);
        end while (!(awready && wready));
        @(posedge clk);
        #DRIVE_DELAY;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do begin
            @(negedge clk);
        end while (!bvalid);
        resp = bresp;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic hostRead(input csrPkg::hostOffT addr, output csrPkg::dataT data,
                            output csrPkg::axiRespT resp);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        do begin
            @(negedge clk);
        end while (!arready);
        @(posedge clk);
        #DRIVE_DELAY;
        arvalid = 1'b0;
        do begin
            @(negedge clk);
        end while (!rvalid);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    initial begin
        csrPkg::dataT      val;
        csrPkg::dataT      first;
        csrPkg::dataT      second;
        csrPkg::dataT      target;
        csrPkg::axiRespT   resp;
        csrPkg::csrReqT    req;
        csrPkg::exceptVecT ev;
        int                pick;

        void'($urandom(32'h9136));
        clk        = 1'b0;
        arstN      = 1'b0;
        csrReq     = '0;
        exceptVec  = '0;
        pc         = '0;
        trapReturn = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b1;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arstN = 1'b1;

        writeThenRead(csrPkg::CSR_MSCRATCH);
        writeThenRead(csrPkg::CSR_MTVEC);
        writeThenRead(csrPkg::CSR_MEPC);
        writeThenRead(csrPkg::CSR_MCAUSE);
        req       = '0;
        req.valid = 1'b1;
        req.write = 1'b1;
        req.addr  = UNKNOWN_CSR;
        req.wdata = {$urandom, $urandom};
        coreStep(req, '0, '0, 1'b0);
        coreRead(UNKNOWN_CSR, val);
        checkValue(val, '0, "unknown CSR read");
        coreRead(csrPkg::CSR_MSCRATCH, val);

        // Return to user with MPIE set
        req       = '0;
        req.valid = 1'b1;
        req.write = 1'b1;
        req.addr  = csrPkg::CSR_MSTATUS;
        req.wdata = 64'h80;
        coreStep(req, '0, '0, 1'b0);
        coreStep('0, '0, '0, 1'b1);
        checkTrue(privMode == csrPkg::PRIV_USER, "user mode after return");
        coreRead(csrPkg::CSR_MSTATUS, val);
        checkTrue(val[3], "MIE set after return");

        // Single trap from user mode, then the stacked state
        ev = csrPkg::exceptVecT'($urandom);
        if (ev == '0) begin
            ev = 16'h0004;
        end
        coreStep('0, ev, {$urandom, $urandom}, 1'b0);
        coreRead(csrPkg::CSR_MCAUSE, val);
        coreRead(csrPkg::CSR_MEPC, val);
        coreRead(csrPkg::CSR_MSTATUS, val);
        checkTrue(!val[3] && val[7], "MIE stacked into MPIE on trap");
        checkTrue(privMode == csrPkg::PRIV_MACHINE, "machine mode after trap");

        repeat (RANDOM_OPS) begin
            pick      = $urandom % 8;
            req       = '0;
            req.valid = 1'b1;
            req.write = (pick != 3) && (pick < 6);
            req.addr  = pickAddr();
            req.wdata = {$urandom, $urandom};
            ev        = (pick == 4) ? csrPkg::exceptVecT'($urandom) : '0;
            coreStep(req, ev, {$urandom, $urandom}, (pick == 4) || (pick == 5));
        end

        // Host halt
        hostWrite(csrPkg::HOST_CTRL, 64'h1, resp);
        checkTrue(resp == csrPkg::RESP_OKAY, "OKAY on control write");
        hostRead(csrPkg::HOST_CYCLE, first, resp);
        hostRead(csrPkg::HOST_CYCLE, second, resp);
        checkValue(second, first, "mcycle while halted");
        hostRead(csrPkg::HOST_STATUS, val, resp);
        checkTrue(resp == csrPkg::RESP_OKAY, "OKAY on status read");
        checkTrue(val[0] && stall, "stalled status while halted");
        checkTrue(val[2:1] == model.mode, "privMode in host status");
        coreRead(csrPkg::CSR_MCYCLE, val);
        checkValue(val, first, "core view of halted mcycle");
        req       = '0;
        req.valid = 1'b1;
        req.write = 1'b1;
        req.addr  = csrPkg::CSR_MCYCLE;
        req.wdata = {$urandom, $urandom};
        coreStep(req, '0, '0, 1'b0);
        coreRead(csrPkg::CSR_MCYCLE, val);
        checkValue(val, first, "mcycle after core write");
        hostWrite(csrPkg::HOST_CTRL, 64'h0, resp);
        hostRead(csrPkg::HOST_CYCLE, second, resp);
        checkTrue(second > first, "mcycle counting after halt release");

        // Armed compare
        hostRead(csrPkg::HOST_CYCLE, val, resp);
        target = val + csrPkg::dataT'(20 + $urandom % 81);
        hostWrite(csrPkg::HOST_CMP, target, resp);
        hostWrite(csrPkg::HOST_CTRL, 64'h2, resp);
        do begin
            @(negedge clk);
        end while (!stall);
        @(posedge clk);
        #DRIVE_DELAY;
        hostRead(csrPkg::HOST_CYCLE, val, resp);
        checkValue(val, target, "mcycle at compare stop");
        hostWrite(csrPkg::HOST_CTRL, 64'h0, resp);
        hostRead(csrPkg::HOST_CYCLE, val, resp);
        checkTrue(val > target && !stall, "counter released after disarm");

        // Error responses
        hostWrite(8'h20, 64'hFF, resp);
        checkTrue(resp == csrPkg::RESP_SLVERR, "SLVERR on unmapped write");
        hostWrite(csrPkg::HOST_CYCLE, 64'h0, resp);
        checkTrue(resp == csrPkg::RESP_SLVERR, "SLVERR on HOST_CYCLE write");
        hostRead(8'h28, val, resp);
        checkTrue(resp == csrPkg::RESP_SLVERR, "SLVERR on unmapped read");
        hostRead(csrPkg::HOST_CMP, val, resp);
        checkValue(val, target, "compare after rejected writes");
        hostRead(csrPkg::HOST_CTRL, val, resp);
        checkValue(val, '0, "control after rejected writes");
        hostRead(csrPkg::HOST_CYCLE, val, resp);
        checkTrue(val > target, "mcycle kept after rejected write");

        // Write response back-pressure
        first   = {$urandom, $urandom};
        bready  = 1'b0;
        awaddr  = csrPkg::HOST_CMP;
        wdata   = first;
        wstrb   = 8'hFF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do begin
            @(negedge clk);
        end while (!awready);
        @(posedge clk);
        #DRIVE_DELAY;
        wdata = ~first;
        repeat (BP_CYCLES) begin
            @(negedge clk);
            checkTrue(bvalid && !awready, "write channel held by pending response");
        end
        @(posedge clk);
        #DRIVE_DELAY;
        bready = 1'b1;
        do begin
            @(negedge clk);
        end while (!(awready && wready));
        @(posedge clk);
        #DRIVE_DELAY;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do begin
            @(negedge clk);
        end while (!bvalid);
        @(posedge clk);
        #DRIVE_DELAY;
        hostRead(csrPkg::HOST_CMP, val, resp);
        checkValue(val, ~first, "compare after second write");

        $display("TEST PASS");
        $finish;
    end

endmodule

/* src.f */
csrPkg.sv
mstatusReg.sv
trapUnit.sv
cycleCounter.sv
hostBridge.sv
machineCsrUnit.sv
machineCsr_props.sv
machineCsrTb.sv

/* Makefile */
SIM      ?= verilator
TOP      ?= machineCsrTb
FILELIST ?= src.f
OBJDIR   ?= obj_dir
SIMFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: SIM TOP FILELIST OBJDIR SIMFLAGS"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)
